/* vlog.f */
+incdir+common
common/bank_mem_pkg.sv
common/mem_lane_if.sv
src/lane_gate.sv
bank_array/bank_array.sv
src/read_port.sv
src/bank_mem_top.sv
sim/tb_clock_gen.sv
sim/bank_mem_checker.sv
sim/bank_mem_assert.sv
sim/bank_mem_tb.sv

/* sim/bank_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bank_mem_macros.svh"

module bank_mem_tb;

    localparam int BANK_W       = $clog2(`MEM_BANKS);
    localparam int ROW_W        = $clog2(`MEM_DEPTH);
    localparam int RESET_CYCLES = 16;
    localparam int RAND_CYCLES  = 400;
    // each directed test with its closing idle and flush cycles.
    localparam int TEST_CYCLES     = 11 + 19 + 11 + 12 + 8 + RAND_CYCLES + 3;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 100;

    logic                             clk;
    logic                             rst;
    logic                             last_stage;
    logic                             r_enable;
    logic                             w_enable;
    logic [`MEM_LANES*BANK_W-1:0]      rd_bank;
    logic [`MEM_LANES*ROW_W-1:0]       rd_row;
    logic [`MEM_LANES*BANK_W-1:0]      wr_bank;
    logic [`MEM_LANES*ROW_W-1:0]       wr_row;
    logic [`MEM_LANES*`MEM_WORD_W-1:0] wr_data;
    logic [`MEM_LANES*`MEM_WORD_W-1:0] rd_data;
    logic [`MEM_LANES*BANK_W-1:0]      rd_bank_out;
    logic [`MEM_LANES*ROW_W-1:0]       rd_row_out;
    logic                             r_enable_out;
    logic                             w_enable_out;
    int                               check_count;
    int                               error_count;
    int                               errors_before;
    int                               test_count;
    logic [31:0]                      rand_state;

    logic [BANK_W-1:0]      lane_rd_bank [`MEM_LANES];
    logic [ROW_W-1:0]       lane_rd_row  [`MEM_LANES];
    logic [BANK_W-1:0]      lane_wr_bank [`MEM_LANES];
    logic [ROW_W-1:0]       lane_wr_row  [`MEM_LANES];
    logic [`MEM_WORD_W-1:0] lane_wr_data [`MEM_LANES];

    tb_clock_gen #(.PERIOD_NS(10.0)) u_clock (.clk(clk));

    bank_mem_top UUT (
        .clk(clk), .rst(rst), .last_stage(last_stage), .r_enable(r_enable),
        .w_enable(w_enable), .rd_bank(rd_bank), .rd_row(rd_row), .wr_bank(wr_bank),
        .wr_row(wr_row), .wr_data(wr_data), .rd_data(rd_data), .rd_bank_out(rd_bank_out),
        .rd_row_out(rd_row_out), .r_enable_out(r_enable_out), .w_enable_out(w_enable_out)
    );

    bank_mem_checker u_checker (
        .clk(clk), .rst(rst), .last_stage(last_stage), .r_enable(r_enable),
        .w_enable(w_enable), .rd_bank(rd_bank), .rd_row(rd_row), .wr_bank(wr_bank),
        .wr_row(wr_row), .wr_data(wr_data), .rd_data(rd_data), .rd_bank_out(rd_bank_out),
        .rd_row_out(rd_row_out), .r_enable_out(r_enable_out), .w_enable_out(w_enable_out),
        .check_count(check_count), .error_count(error_count)
    );

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    task automatic set_lane(input int l, input int rb, input int rr, input int wb, input int wr,
            input logic [`MEM_WORD_W-1:0] wd);
        lane_rd_bank[l] = rb[BANK_W-1:0];
        lane_rd_row[l]  = rr[ROW_W-1:0];
        lane_wr_bank[l] = wb[BANK_W-1:0];
        lane_wr_row[l]  = wr[ROW_W-1:0];
        lane_wr_data[l] = wd;
    endtask

    // drives one cycle of lane requests on the next falling edge.
    task automatic apply_cycle(input logic ls, input logic ren, input logic wen);
        @(negedge clk);
        last_stage = ls;
        r_enable   = ren;
        w_enable   = wen;
        for (int l = 0; l < `MEM_LANES; l++) begin
            rd_bank[l*BANK_W +: BANK_W]         = lane_rd_bank[l];
            rd_row[l*ROW_W +: ROW_W]            = lane_rd_row[l];
            wr_bank[l*BANK_W +: BANK_W]         = lane_wr_bank[l];
            wr_row[l*ROW_W +: ROW_W]            = lane_wr_row[l];
            wr_data[l*`MEM_WORD_W +: `MEM_WORD_W] = lane_wr_data[l];
        end
    endtask

    task automatic end_test(input string name);
        int errs;
        @(posedge clk);
        @(negedge clk);
        #1; // the checker compares on this falling edge.
        errs = error_count - errors_before;
        test_count++;
        $display("test %0d %s: %s, %0d mismatches", test_count, name,
                 (errs == 0) ? "ok" : "failed", errs);
        errors_before = error_count;
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] lane_rnd;
        int          total_errors;
        rand_state    = 32'h3914;
        errors_before = 0;
        test_count    = 0;
        rst           = 1'b0;
        last_stage    = 1'b0;
        r_enable      = 1'b0;
        w_enable      = 1'b0;
        rd_bank       = '0;
        rd_row        = '0;
        wr_bank       = '0;
        wr_row        = '0;
        wr_data       = '0;
        for (int l = 0; l < `MEM_LANES; l++) set_lane(l, 0, 0, 0, 0, '0);
        #1;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int c = 0; c < `MEM_DEPTH; c++) begin
            for (int l = 0; l < `MEM_LANES; l++) set_lane(l, l, c, 0, 0, '0);
            apply_cycle(1'b0, 1'b1, 1'b0);
        end
        apply_cycle(1'b0, 1'b0, 1'b0);
        end_test("read after reset");

        for (int c = 0; c < `MEM_DEPTH; c++) begin
            for (int l = 0; l < `MEM_LANES; l++) begin
                rnd = lcg_next();
                set_lane(l, 0, 0, l, c, rnd[31:16]);
            end
            apply_cycle(1'b0, 1'b0, 1'b1);
        end
        for (int c = 0; c < `MEM_DEPTH; c++) begin
            for (int l = 0; l < `MEM_LANES; l++) set_lane(l, (l + 1) % `MEM_BANKS, c, 0, 0, '0);
            apply_cycle(1'b0, 1'b1, 1'b0);
        end
        apply_cycle(1'b0, 1'b0, 1'b0);
        end_test("write then read");

        for (int k = 0; k < 4; k++) begin
            for (int l = 0; l < `MEM_LANES; l++) begin
                rnd = lcg_next();
                set_lane(l, l, k + 4, l, k + 4, rnd[31:16]);
            end
            apply_cycle(1'b0, 1'b1, 1'b1); // old data comes back.
            apply_cycle(1'b0, 1'b1, 1'b0); // new data comes back.
        end
        apply_cycle(1'b0, 1'b0, 1'b0);
        end_test("read during write");

        for (int l = 0; l < `MEM_LANES; l++) set_lane(l, l, 1, 0, 0, '0);
        apply_cycle(1'b0, 1'b1, 1'b0);
        for (int c = 0; c < 4; c++) begin
            for (int l = 0; l < `MEM_LANES; l++) begin
                rnd = lcg_next();
                set_lane(l, (l + 2) % `MEM_BANKS, c, l, c, rnd[31:16]);
            end
            apply_cycle(1'b1, 1'b1, 1'b1);
        end
        for (int c = 0; c < 4; c++) begin
            for (int l = 0; l < `MEM_LANES; l++) set_lane(l, l, c, 0, 0, '0);
            apply_cycle(1'b0, 1'b1, 1'b0);
        end
        apply_cycle(1'b0, 1'b0, 1'b0);
        end_test("last stage");

        for (int l = 0; l < `MEM_LANES; l++) begin
            rnd = lcg_next();
            set_lane(l, l, 2, l, 3, rnd[31:16]);
        end
        apply_cycle(1'b0, 1'b1, 1'b0);
        apply_cycle(1'b0, 1'b0, 1'b0);
        apply_cycle(1'b0, 1'b0, 1'b1);
        apply_cycle(1'b0, 1'b1, 1'b0);
        apply_cycle(1'b0, 1'b1, 1'b1);
        apply_cycle(1'b0, 1'b0, 1'b0);
        end_test("idle and enable echo");

        for (int n = 0; n < RAND_CYCLES; n++) begin
            rnd = lcg_next();
            for (int l = 0; l < `MEM_LANES; l++) begin
                lane_rnd = lcg_next();
                set_lane(l, lane_rnd[31:30], lane_rnd[29:27], lane_rnd[26:25], lane_rnd[24:22],
                         lane_rnd[21:6]);
            end
            if (rnd[25:24] == 2'd0) begin // every write lane aims at lane 0's word.
                for (int l = 1; l < `MEM_LANES; l++) begin
                    lane_wr_bank[l] = lane_wr_bank[0];
                    lane_wr_row[l]  = lane_wr_row[0];
                end
                lane_rd_bank[0] = lane_wr_bank[0];
                lane_rd_row[0]  = lane_wr_row[0];
            end
            apply_cycle(rnd[31:30] == 2'd0, rnd[29:28] != 2'd0, rnd[27:26] != 2'd0);
        end
        apply_cycle(1'b0, 1'b0, 1'b0);
        end_test("random traffic");

        total_errors = error_count + UUT.u_assert.fail_count;
        $display("summary: %0d tests, %0d cycles compared, %0d mismatches, %0d assertion failures",
                 test_count, check_count, error_count, UUT.u_assert.fail_count);
        if (total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not complete within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/bank_mem_assert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bank_mem_macros.svh"

module bank_mem_assert (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            r_enable,
    input  logic                            w_enable,
    input  logic                            r_enable_out,
    input  logic                            w_enable_out,
    input  logic [`MEM_LANES*`MEM_WORD_W-1:0] rd_data
);

    int fail_count = 0;

    a_enables_low_in_reset: assert property (@(posedge clk) rst |-> !r_enable_out && !w_enable_out)
        else begin
            fail_count++;
            $error("enable outputs are not low during reset");
        end

    // a cycle without a read leaves every lane zeroed.
    a_idle_zeroes_data: assert property (@(posedge clk) disable iff (rst)
        !r_enable |=> rd_data == '0)
        else begin
            fail_count++;
            $error("rd_data is not zero after a cycle with r_enable low");
        end

    a_write_enable_echo: assert property (@(posedge clk) disable iff (rst)
        w_enable |=> w_enable_out)
        else begin
            fail_count++;
            $error("w_enable_out did not follow w_enable");
        end

endmodule

bind bank_mem_top bank_mem_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .r_enable     (r_enable),
    .w_enable     (w_enable),
    .r_enable_out (r_enable_out),
    .w_enable_out (w_enable_out),
    .rd_data      (rd_data)
);

`default_nettype wire

/* sim/bank_mem_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bank_mem_macros.svh"

module bank_mem_checker #(
    parameter int BANK_W = $clog2(`MEM_BANKS),
    parameter int ROW_W  = $clog2(`MEM_DEPTH)
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            last_stage,
    input  logic                            r_enable,
    input  logic                            w_enable,
    input  logic [`MEM_LANES*BANK_W-1:0]     rd_bank,
    input  logic [`MEM_LANES*ROW_W-1:0]      rd_row,
    input  logic [`MEM_LANES*BANK_W-1:0]     wr_bank,
    input  logic [`MEM_LANES*ROW_W-1:0]      wr_row,
    input  logic [`MEM_LANES*`MEM_WORD_W-1:0] wr_data,
    input  logic [`MEM_LANES*`MEM_WORD_W-1:0] rd_data,
    input  logic [`MEM_LANES*BANK_W-1:0]     rd_bank_out,
    input  logic [`MEM_LANES*ROW_W-1:0]      rd_row_out,
    input  logic                            r_enable_out,
    input  logic                            w_enable_out,
    output int                              check_count,
    output int                              error_count
);

    localparam int RES_W = `MEM_WORD_W + BANK_W + ROW_W;

    logic [`MEM_WORD_W-1:0] model [`MEM_BANKS*`MEM_DEPTH]; // bank-major word store.
    logic [RES_W-1:0]       exp_lane [`MEM_LANES];          // {data, bank, row} per lane.
    logic                   exp_ren;
    logic                   exp_wen;
    logic                   exp_valid;

    function automatic logic lane_active(input logic en, input logic ls, input int lane);
        int lanes;
        lanes = ls ? `LAST_STAGE_LANES : `MEM_LANES;
        return en && (lane < lanes);
    endfunction

    // next registered result of one read lane, looked up before this edge's writes.
    function automatic logic [RES_W-1:0] ref_read_lane(input logic ren, input logic ls,
            input int lane, input logic [BANK_W-1:0] bank, input logic [ROW_W-1:0] row,
            input logic [RES_W-1:0] prev);
        if (!ren) return '0;
        if (!lane_active(ren, ls, lane)) return prev; // left-out lanes hold.
        return {model[int'(bank)*`MEM_DEPTH + int'(row)], bank, row};
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
            input logic [31:0] exp);
        error_count++;
        $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    initial begin
        check_count = 0;
        error_count = 0;
        exp_valid   = 1'b0;
    end

    // inputs are stable at the rising edge since the testbench drives them on the falling one.
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MEM_BANKS*`MEM_DEPTH; i++) model[i] = '0;
            for (int l = 0; l < `MEM_LANES; l++) exp_lane[l] = '0;
            exp_ren   = 1'b0;
            exp_wen   = 1'b0;
            exp_valid = 1'b1; // every output sits at zero while reset is held.
        end else begin
            for (int l = 0; l < `MEM_LANES; l++) begin
                exp_lane[l] = ref_read_lane(r_enable, last_stage, l,
                    rd_bank[l*BANK_W +: BANK_W], rd_row[l*ROW_W +: ROW_W], exp_lane[l]);
            end
            for (int l = 0; l < `MEM_LANES; l++) begin
                if (lane_active(w_enable, last_stage, l)) begin // in lane order the higher wins.
                    model[int'(wr_bank[l*BANK_W +: BANK_W])*`MEM_DEPTH
                          + int'(wr_row[l*ROW_W +: ROW_W])] = wr_data[l*`MEM_WORD_W +: `MEM_WORD_W];
                end
            end
            exp_ren   = r_enable;
            exp_wen   = w_enable;
            exp_valid = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (exp_valid) begin
            check_count++;
            for (int l = 0; l < `MEM_LANES; l++) begin
                if (rd_data[l*`MEM_WORD_W +: `MEM_WORD_W] !== exp_lane[l][RES_W-1 -: `MEM_WORD_W])
                    report_mismatch($sformatf("lane %0d rd_data", l),
                        rd_data[l*`MEM_WORD_W +: `MEM_WORD_W], exp_lane[l][RES_W-1 -: `MEM_WORD_W]);
                if (rd_bank_out[l*BANK_W +: BANK_W] !== exp_lane[l][ROW_W +: BANK_W])
                    report_mismatch($sformatf("lane %0d rd_bank_out", l),
                        rd_bank_out[l*BANK_W +: BANK_W], exp_lane[l][ROW_W +: BANK_W]);
                if (rd_row_out[l*ROW_W +: ROW_W] !== exp_lane[l][ROW_W-1:0])
                    report_mismatch($sformatf("lane %0d rd_row_out", l),
                        rd_row_out[l*ROW_W +: ROW_W], exp_lane[l][ROW_W-1:0]);
            end
            if (r_enable_out !== exp_ren) report_mismatch("r_enable_out", r_enable_out, exp_ren);
            if (w_enable_out !== exp_wen) report_mismatch("w_enable_out", w_enable_out, exp_wen);
        end
    end

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 10.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

/* src/bank_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bank_mem_macros.svh"

module bank_mem_top (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic                                                  last_stage,
    input  logic                                                  r_enable,
    input  logic                                                  w_enable,
    input  logic [`MEM_LANES*$bits(bank_mem_pkg::bank_t)-1:0]     rd_bank,
    input  logic [`MEM_LANES*$bits(bank_mem_pkg::row_t)-1:0]      rd_row,
    input  logic [`MEM_LANES*$bits(bank_mem_pkg::bank_t)-1:0]     wr_bank,
    input  logic [`MEM_LANES*$bits(bank_mem_pkg::row_t)-1:0]      wr_row,
    input  logic [`MEM_LANES*`MEM_WORD_W-1:0]                     wr_data,
    output logic [`MEM_LANES*`MEM_WORD_W-1:0]                     rd_data,
    output logic [`MEM_LANES*$bits(bank_mem_pkg::bank_t)-1:0]     rd_bank_out,
    output logic [`MEM_LANES*$bits(bank_mem_pkg::row_t)-1:0]      rd_row_out,
    output logic                                                  r_enable_out,
    output logic                                                  w_enable_out
);

    localparam int BANK_W = $bits(bank_mem_pkg::bank_t);
    localparam int ROW_W  = $bits(bank_mem_pkg::row_t);

    bank_mem_pkg::bank_t rd_bank_a [`MEM_LANES];
    bank_mem_pkg::row_t  rd_row_a  [`MEM_LANES];
    bank_mem_pkg::bank_t wr_bank_a [`MEM_LANES];
    bank_mem_pkg::row_t  wr_row_a  [`MEM_LANES];
    bank_mem_pkg::word_t wr_data_a [`MEM_LANES];
    bank_mem_pkg::word_t rd_word   [`MEM_LANES];
    bank_mem_pkg::word_t rd_data_a [`MEM_LANES];
    bank_mem_pkg::bank_t rd_bank_q [`MEM_LANES];
    bank_mem_pkg::row_t  rd_row_q  [`MEM_LANES];

    mem_lane_if rd_req ();
    mem_lane_if wr_req ();

    // lane n sits at field n of every flat vector, lane 0 in the low bits.
    for (genvar l = 0; l < `MEM_LANES; l++) begin : g_lane
        assign rd_bank_a[l] = rd_bank[l*BANK_W +: BANK_W];
        assign rd_row_a[l]  = rd_row[l*ROW_W +: ROW_W];
        assign wr_bank_a[l] = wr_bank[l*BANK_W +: BANK_W];
        assign wr_row_a[l]  = wr_row[l*ROW_W +: ROW_W];
        assign wr_data_a[l] = wr_data[l*`MEM_WORD_W +: `MEM_WORD_W];

        assign rd_data[l*`MEM_WORD_W +: `MEM_WORD_W] = rd_data_a[l];
        assign rd_bank_out[l*BANK_W +: BANK_W]       = rd_bank_q[l];
        assign rd_row_out[l*ROW_W +: ROW_W]          = rd_row_q[l];
    end

    lane_gate u_lane_gate (
        .last_stage (last_stage),
        .r_enable   (r_enable),
        .w_enable   (w_enable),
        .rd_bank    (rd_bank_a),
        .rd_row     (rd_row_a),
        .wr_bank    (wr_bank_a),
        .wr_row     (wr_row_a),
        .wr_data    (wr_data_a),
        .rd_req     (rd_req),
        .wr_req     (wr_req)
    );

    bank_array u_bank_array (
        .clk     (clk),
        .rst     (rst),
        .rd_req  (rd_req),
        .wr_req  (wr_req),
        .rd_word (rd_word)
    );

    read_port u_read_port (
        .clk          (clk),
        .rst          (rst),
        .r_enable     (r_enable),
        .w_enable     (w_enable),
        .rd_req       (rd_req),
        .rd_word      (rd_word),
        .rd_data      (rd_data_a),
        .rd_bank_out  (rd_bank_q),
        .rd_row_out   (rd_row_q),
        .r_enable_out (r_enable_out),
        .w_enable_out (w_enable_out)
    );

endmodule

`default_nettype wire

/* src/read_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bank_mem_macros.svh"

module read_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                r_enable,
    input  logic                w_enable,
    mem_lane_if.dst             rd_req,
    input  bank_mem_pkg::word_t rd_word     [`MEM_LANES],
    output bank_mem_pkg::word_t rd_data     [`MEM_LANES],
    output bank_mem_pkg::bank_t rd_bank_out [`MEM_LANES],
    output bank_mem_pkg::row_t  rd_row_out  [`MEM_LANES],
    output logic                r_enable_out,
    output logic                w_enable_out
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            r_enable_out <= 1'b0;
            w_enable_out <= 1'b0;
        end else begin
            r_enable_out <= r_enable;
            w_enable_out <= w_enable;
        end
    end

    // each lane captures its word together with the indices it was read from.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int l = 0; l < `MEM_LANES; l++) begin
                rd_data[l]     <= '0;
                rd_bank_out[l] <= '0;
                rd_row_out[l]  <= '0;
            end
        end else begin
            for (int l = 0; l < `MEM_LANES; l++) begin
                if (!r_enable) begin
                    rd_data[l]     <= '0; // no read this cycle clears every lane.
                    rd_bank_out[l] <= '0;
                    rd_row_out[l]  <= '0;
                end else if (rd_req.active[l]) begin
                    rd_data[l]     <= rd_word[l];
                    rd_bank_out[l] <= rd_req.bank[l];
                    rd_row_out[l]  <= rd_req.row[l];
                end
                // lanes left out by the last stage keep their previous result.
            end
        end
    end

endmodule

`default_nettype wire

/* bank_array/bank_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bank_mem_macros.svh"

module bank_array (
    input  logic                clk,
    input  logic                rst,
    mem_lane_if.dst             rd_req,
    mem_lane_if.dst             wr_req,
    output bank_mem_pkg::word_t rd_word [`MEM_LANES]
);

    bank_mem_pkg::word_t mem [`MEM_BANKS][`MEM_DEPTH];

    // writes are applied lane by lane in ascending order.
    // when two lanes hit the same word the later assignment, the higher lane, sticks.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int b = 0; b < `MEM_BANKS; b++) begin
                for (int r = 0; r < `MEM_DEPTH; r++) begin
                    mem[b][r] <= '0;
                end
            end
        end else begin
            for (int l = 0; l < `MEM_LANES; l++) begin
                if (wr_req.active[l]) begin
                    mem[wr_req.bank[l]][wr_req.row[l]] <= wr_req.data[l];
                end
            end
        end
    end

    // reads see the contents from before this edge's writes.
    always_comb begin
        for (int l = 0; l < `MEM_LANES; l++) begin
            rd_word[l] = mem[rd_req.bank[l]][rd_req.row[l]];
        end
    end

endmodule

`default_nettype wire

/* src/lane_gate.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bank_mem_macros.svh"

module lane_gate (
    input  logic                last_stage,
    input  logic                r_enable,
    input  logic                w_enable,
    input  bank_mem_pkg::bank_t rd_bank [`MEM_LANES],
    input  bank_mem_pkg::row_t  rd_row  [`MEM_LANES],
    input  bank_mem_pkg::bank_t wr_bank [`MEM_LANES],
    input  bank_mem_pkg::row_t  wr_row  [`MEM_LANES],
    input  bank_mem_pkg::word_t wr_data [`MEM_LANES],
    mem_lane_if.src             rd_req,
    mem_lane_if.src             wr_req
);

    bank_mem_pkg::lane_mask_t mode_mask;

    // the last stage only uses the lowest lanes, every other stage uses them all.
    always_comb begin
        mode_mask = '0;
        for (int l = 0; l < `MEM_LANES; l++) begin
            mode_mask[l] = !last_stage || (l < `LAST_STAGE_LANES);
        end
    end

    always_comb begin
        rd_req.active = r_enable ? mode_mask : '0;
        for (int l = 0; l < `MEM_LANES; l++) begin
            rd_req.bank[l] = rd_bank[l];
            rd_req.row[l]  = rd_row[l];
            rd_req.data[l] = '0; // reads carry no payload.
        end
    end

    always_comb begin
        wr_req.active = w_enable ? mode_mask : '0;
        for (int l = 0; l < `MEM_LANES; l++) begin
            wr_req.bank[l] = wr_bank[l];
            wr_req.row[l]  = wr_row[l];
            wr_req.data[l] = wr_data[l];
        end
    end

endmodule

`default_nettype wire

/* common/mem_lane_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bank_mem_macros.svh"

// one direction of lane requests, either the reads or the writes of a cycle.
interface mem_lane_if;

    bank_mem_pkg::lane_mask_t active;
    bank_mem_pkg::bank_t      bank [`MEM_LANES];
    bank_mem_pkg::row_t       row  [`MEM_LANES];
    bank_mem_pkg::word_t      data [`MEM_LANES]; // only meaningful for writes.

    modport src (
        output active,
        output bank,
        output row,
        output data
    );

    modport dst (
        input active,
        input bank,
        input row,
        input data
    );

endinterface

`default_nettype wire

/* common/bank_mem_pkg.sv */
`default_nettype none

`include "bank_mem_macros.svh"

package bank_mem_pkg;

    // one stored coefficient.
    typedef logic [`MEM_WORD_W-1:0] word_t;

    typedef logic [$clog2(`MEM_BANKS)-1:0] bank_t; // selects one bank.

    typedef logic [$clog2(`MEM_DEPTH)-1:0] row_t; // selects a row inside a bank.

    // bit n is set when lane n takes part in the access.
    typedef logic [`MEM_LANES-1:0] lane_mask_t;

endpackage

`default_nettype wire

/* common/bank_mem_macros.svh */
`ifndef BANK_MEM_MACROS_SVH
`define BANK_MEM_MACROS_SVH

// number of access lanes served every cycle.
`define MEM_LANES 4

// number of independent banks.
`define MEM_BANKS 4

// rows held in each bank.
`define MEM_DEPTH 8

`define MEM_WORD_W 16 // coefficient width in bits.

// in the last transform stage only the lowest lanes take part.
`define LAST_STAGE_LANES 2

`endif
